// ==== source/exec_pkg.sv ====
package exec_pkg;

	// ====================
	// ALU opcodes.
	localparam logic [4:0] ALU_ADD   = 5'h00;
	localparam logic [4:0] ALU_ADDC  = 5'h01;
	localparam logic [4:0] ALU_SUB   = 5'h02;
	localparam logic [4:0] ALU_SUBC  = 5'h03;
	localparam logic [4:0] ALU_LSL   = 5'h04;
	localparam logic [4:0] ALU_LSR   = 5'h05;
	localparam logic [4:0] ALU_AND   = 5'h06;
	localparam logic [4:0] ALU_XOR   = 5'h07;
	localparam logic [4:0] ALU_BIC   = 5'h08;
	localparam logic [4:0] ALU_BST   = 5'h09;
	localparam logic [4:0] ALU_OR    = 5'h0a;
	localparam logic [4:0] ALU_COPYB = 5'h0b;
	localparam logic [4:0] ALU_CMP   = 5'h0c;
	localparam logic [4:0] ALU_MOVHI = 5'h0d;
	localparam logic [4:0] ALU_ASR   = 5'h0e;
	localparam logic [4:0] ALU_COPYA = 5'h0f;
	localparam logic [4:0] ALU_GCR   = 5'h10;
	localparam logic [4:0] ALU_SWI   = 5'h11;
	localparam logic [4:0] ALU_RFE   = 5'h12;

	// ====================
	// Instruction classes and branch conditions.
	localparam logic [1:0] CLASS_ARITH  = 2'd0;
	localparam logic [1:0] CLASS_BRANCH = 2'd1;
	localparam logic [1:0] CLASS_MEM    = 2'd2;
	localparam logic [1:0] CLASS_MISC   = 2'd3;

	localparam logic [2:0] BR_NE     = 3'd1;
	localparam logic [2:0] BR_EQ     = 3'd2;
	localparam logic [2:0] BR_NC     = 3'd3;
	localparam logic [2:0] BR_C      = 3'd4;
	localparam logic [2:0] BR_GT     = 3'd5;
	localparam logic [2:0] BR_LT     = 3'd6;
	localparam logic [2:0] BR_ALWAYS = 3'd7;

	// First ALU operand source.
	localparam logic [1:0] OP1_RA = 2'd0;
	localparam logic [1:0] OP1_RB = 2'd1;
	localparam logic [1:0] OP1_PC = 2'd2;

	// ====================
	// Pipeline bundles.
	typedef struct packed {
		logic [31:0] ra, rb, imm32, pc_plus_4;
		logic [3:0]  rd_sel;
		logic        update_rd;
		logic [4:0]  alu_opc;
		logic [1:0]  op1_src;
		logic        op2_rb;
		logic        mem_load, mem_store;
		logic [1:0]  mem_width;
		logic [2:0]  branch_cond;
		logic [1:0]  instr_class;
		logic        is_call, update_carry, update_flags;
		logic [2:0]  cr_sel;
		logic        write_cr;
		logic        is_swi, is_rfe, valid;
	} exec_op_t;

	typedef struct packed {
		logic [31:0] alu_out, wr_val;
		logic        wr_result;
		logic [3:0]  rd_sel;
		logic        mem_load, mem_store, mem_wr_en;
		logic [1:0]  mem_width;
		logic [31:0] mar, mdr, pc_plus_4;
		logic        valid;
	} exec_result_t;

endpackage

// ==== source/cr_pkg.sv ====
package cr_pkg;

	// ====================
	// Control register indices.
	localparam logic [2:0] CR_VECTOR    = 3'd0;
	localparam logic [2:0] CR_PSR       = 3'd1;
	localparam logic [2:0] CR_SAVED_PSR = 3'd2;
	localparam logic [2:0] CR_FAULT     = 3'd3;
	localparam logic [2:0] CR_DFAULT    = 3'd4;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	typedef struct packed {
		logic irq_en;
		logic n;
		logic o;
		logic c;
		logic z;
	} psr_t;

	typedef struct packed {
		logic exception_start;
		logic exception_disable_irqs;
		logic data_abort;
	} exc_event_t;

	// ====================
	// AXI4-Lite channel payloads.
	typedef struct packed {
		logic [31:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [31:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axil_w_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} axil_r_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

endpackage

// ==== source/exec_alu.sv ====
module exec_alu (
	input  logic [4:0]  i_opc,
	input  logic [31:0] i_op1,
	input  logic [31:0] i_op2,
	input  logic        i_carry_in,
	input  logic [31:0] i_cr_val,
	input  logic [25:0] i_vector_base,
	input  logic [31:0] i_fault_addr,
	output logic [31:0] o_result,
	output logic        o_c,
	output logic        o_o,
	output logic        o_n,
	output logic        o_z
);
	import exec_pkg::*;

	logic [32:0] sum;
	logic [32:0] diff;

	assign sum  = {1'b0, i_op1} + {1'b0, i_op2};
	assign diff = {1'b0, i_op1} - {1'b0, i_op2};

	always_comb begin
		o_result = 32'b0;
		o_c = 1'b0;
		o_o = 1'b0;
		o_n = 1'b0;

		case (i_opc)
			ALU_ADD:   {o_c, o_result} = sum;
			ALU_ADDC:  {o_c, o_result} = sum + {32'b0, i_carry_in};
			ALU_SUB:   {o_c, o_result} = diff;
			ALU_SUBC:  {o_c, o_result} = diff - {32'b0, i_carry_in};
			ALU_LSL:   {o_c, o_result} = {1'b0, i_op1} << i_op2[4:0];
			ALU_LSR:   o_result = i_op1 >> i_op2[4:0];
			ALU_AND:   o_result = i_op1 & i_op2;
			ALU_XOR:   o_result = i_op1 ^ i_op2;
			ALU_BIC:   o_result = i_op1 & ~(32'b1 << i_op2[4:0]);
			ALU_BST:   o_result = i_op1 | (32'b1 << i_op2[4:0]);
			ALU_OR:    o_result = i_op1 | i_op2;
			ALU_COPYB: o_result = i_op2;
			ALU_CMP: begin
				{o_c, o_result} = diff;
				// Signed overflow when the operand signs differ and the result follows op2.
				o_o = (i_op1[31] ^ i_op2[31]) && (o_result[31] == i_op2[31]);
				o_n = o_result[31];
			end
			ALU_MOVHI: o_result = i_op1 | {16'b0, i_op2[15:0]};
			ALU_ASR:   o_result = $signed(i_op1) >>> i_op2[4:0];
			ALU_COPYA: o_result = i_op1;
			ALU_GCR:   o_result = i_cr_val;
			// Software interrupt entry sits 8 bytes into the vector table.
			ALU_SWI:   o_result = {i_vector_base, 6'h08};
			ALU_RFE:   o_result = i_fault_addr;
			default:   o_result = 32'b0;
		endcase
	end

	assign o_z = (i_op1 == i_op2);

endmodule

// ==== source/control_regs.sv ====
module control_regs (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_flags_wr,
	input  logic               i_carry_wr,
	input  logic               i_alu_c,
	input  logic               i_alu_o,
	input  logic               i_alu_n,
	input  logic               i_alu_z,
	input  logic [2:0]         i_cr_sel,
	input  logic               i_cr_wr_en,
	input  logic [31:0]        i_cr_wr_val,
	input  logic               i_is_swi,
	input  logic               i_is_rfe,
	input  cr_pkg::exc_event_t i_exc,
	input  logic [31:0]        i_pc_plus_4,
	input  logic [31:0]        i_mar,
	input  logic [2:0]         i_dbg_sel,
	input  logic               i_dbg_wr_en,
	input  logic [31:0]        i_dbg_wr_val,
	output cr_pkg::psr_t       o_psr,
	output logic [31:0]        o_cr_val,
	output logic [31:0]        o_dbg_val,
	output logic [25:0]        o_vector_base,
	output logic [31:0]        o_fault_addr
);
	import cr_pkg::*;

	psr_t        psr_q;
	psr_t        saved_psr;
	logic [25:0] vector_addr;
	logic [31:0] fault_addr;
	logic [31:0] dfault_addr;
	logic [7:0]  dbg_wr;
	logic [7:0]  pipe_wr;
	logic [31:0] cr_file [8];

	assign dbg_wr  = i_dbg_wr_en ? (8'b1 << i_dbg_sel) : 8'b0;
	assign pipe_wr = i_cr_wr_en ? (8'b1 << i_cr_sel) : 8'b0;

	// Unimplemented indices read as zero.
	always_comb begin
		cr_file = '{default: 32'b0};
		cr_file[CR_VECTOR]    = {vector_addr, 6'b0};
		cr_file[CR_PSR]       = {27'b0, psr_q};
		cr_file[CR_SAVED_PSR] = {27'b0, saved_psr};
		cr_file[CR_FAULT]     = fault_addr;
		cr_file[CR_DFAULT]    = dfault_addr;
	end

	assign o_cr_val  = cr_file[i_cr_sel];
	assign o_dbg_val = cr_file[i_dbg_sel];

	// ====================
	// Processor status.
	always_ff @(posedge clk) begin
		if (rst) begin
			psr_q <= '0;
		end else if (dbg_wr[CR_PSR]) begin
			psr_q <= i_dbg_wr_val[4:0];
		end else if (i_is_rfe) begin
			psr_q <= saved_psr;
		end else begin
			if (pipe_wr[CR_PSR]) begin
				psr_q <= i_cr_wr_val[4:0];
			end else begin
				if (i_flags_wr) begin
					psr_q.z <= i_alu_z;
					psr_q.n <= i_alu_n;
					psr_q.o <= i_alu_o;
				end
				if (i_carry_wr)
					psr_q.c <= i_alu_c;
			end
			if (i_exc.exception_disable_irqs)
				psr_q.irq_en <= 1'b0;
		end
	end

	// ====================
	// Vector base, saved status and fault addresses.
	always_ff @(posedge clk) begin
		if (rst)
			vector_addr <= 26'b0;
		else if (dbg_wr[CR_VECTOR])
			vector_addr <= i_dbg_wr_val[31:6];
		else if (pipe_wr[CR_VECTOR])
			vector_addr <= i_cr_wr_val[31:6];
	end

	always_ff @(posedge clk) begin
		if (rst)
			saved_psr <= '0;
		else if (dbg_wr[CR_SAVED_PSR])
			saved_psr <= i_dbg_wr_val[4:0];
		else if (i_is_swi || i_exc.exception_start || i_exc.exception_disable_irqs)
			saved_psr <= psr_q;
		else if (pipe_wr[CR_SAVED_PSR])
			saved_psr <= i_cr_wr_val[4:0];
	end

	always_ff @(posedge clk) begin
		if (rst)
			fault_addr <= 32'b0;
		else if (dbg_wr[CR_FAULT])
			fault_addr <= i_dbg_wr_val;
		else if (i_exc.exception_disable_irqs)
			fault_addr <= i_pc_plus_4;
		else if (pipe_wr[CR_FAULT])
			fault_addr <= i_cr_wr_val;
	end

	always_ff @(posedge clk) begin
		if (rst)
			dfault_addr <= 32'b0;
		else if (dbg_wr[CR_DFAULT])
			dfault_addr <= i_dbg_wr_val;
		else if (i_exc.data_abort)
			dfault_addr <= i_mar;
		else if (pipe_wr[CR_DFAULT])
			dfault_addr <= i_cr_wr_val;
	end

	assign o_psr         = psr_q;
	assign o_vector_base = vector_addr;
	assign o_fault_addr  = fault_addr;

endmodule

// ==== source/dbg_axil_slave.sv ====
module dbg_axil_slave (
	input  logic             clk,
	input  logic             rst,
	input  cr_pkg::axil_aw_t i_aw,
	input  logic             i_aw_valid,
	output logic             o_aw_ready,
	input  cr_pkg::axil_w_t  i_w,
	input  logic             i_w_valid,
	output logic             o_w_ready,
	output cr_pkg::axil_b_t  o_b,
	output logic             o_b_valid,
	input  logic             i_b_ready,
	input  cr_pkg::axil_ar_t i_ar,
	input  logic             i_ar_valid,
	output logic             o_ar_ready,
	output cr_pkg::axil_r_t  o_r,
	output logic             o_r_valid,
	input  logic             i_r_ready,
	output logic [2:0]       o_dbg_sel,
	output logic             o_dbg_wr_en,
	output logic [31:0]      o_dbg_wr_val,
	input  logic [31:0]      i_dbg_val
);
	import cr_pkg::*;

	logic        aw_held;
	logic        w_held;
	logic [31:0] wr_addr;
	logic [31:0] wr_data;
	logic        wr_fire;
	logic        ar_fire;
	logic [31:0] rd_data;

	assign wr_fire    = aw_held && w_held;
	assign o_aw_ready = !aw_held && !o_b_valid;
	assign o_w_ready  = !w_held && !o_b_valid;
	// A read never shares the register select with a write strobe.
	assign o_ar_ready = !o_r_valid && !wr_fire;
	assign ar_fire    = i_ar_valid && o_ar_ready;

	// Registers occupy the first 32 bytes.
	assign o_dbg_wr_en  = wr_fire && (wr_addr[31:5] == 27'b0);
	assign o_dbg_wr_val = wr_data;
	assign o_dbg_sel    = wr_fire ? wr_addr[4:2] : i_ar.addr[4:2];

	// ====================
	// Write path.
	always_ff @(posedge clk) begin
		if (rst) begin
			aw_held   <= 1'b0;
			w_held    <= 1'b0;
			o_b_valid <= 1'b0;
		end else begin
			if (i_aw_valid && o_aw_ready)
				aw_held <= 1'b1;
			if (i_w_valid && o_w_ready)
				w_held <= 1'b1;
			if (wr_fire) begin
				aw_held   <= 1'b0;
				w_held    <= 1'b0;
				o_b_valid <= 1'b1;
			end else if (o_b_valid && i_b_ready) begin
				o_b_valid <= 1'b0;
			end
		end
	end

	// ====================
	// Read path.
	always_ff @(posedge clk) begin
		if (rst)
			o_r_valid <= 1'b0;
		else if (ar_fire)
			o_r_valid <= 1'b1;
		else if (o_r_valid && i_r_ready)
			o_r_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (i_aw_valid && o_aw_ready)
			wr_addr <= i_aw.addr;
		if (i_w_valid && o_w_ready)
			wr_data <= i_w.data;
		if (ar_fire)
			rd_data <= (i_ar.addr[31:5] == 27'b0) ? i_dbg_val : 32'b0;
	end

	assign o_b = '{resp: AXI_RESP_OKAY};
	assign o_r = '{data: rd_data, resp: AXI_RESP_OKAY};

endmodule

// ==== source/exec_stage.sv ====
module exec_stage (
	input  logic                   clk,
	input  logic                   rst,
	input  exec_pkg::exec_op_t     i_op,
	input  cr_pkg::exc_event_t     i_exc,
	input  logic [2:0]             i_dbg_sel,
	input  logic                   i_dbg_wr_en,
	input  logic [31:0]            i_dbg_wr_val,
	output exec_pkg::exec_result_t o_res,
	output logic                   o_branch_taken,
	output logic                   o_stall_clear,
	output logic                   o_irqs_enabled,
	output logic [25:0]            o_vector_base,
	output logic [31:0]            o_dbg_val
);
	import exec_pkg::*;
	import cr_pkg::*;

	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] alu_q;
	logic        alu_c, alu_o, alu_n, alu_z;
	logic [31:0] cr_val;
	logic [31:0] fault_addr;
	psr_t        psr;
	logic        cond_met;
	logic        is_branch;
	logic        upd_flags, upd_carry, cr_wr, swi, rfe, load, store;

	// Nothing from an invalid slot reaches architectural state.
	assign upd_flags = i_op.valid && i_op.update_flags;
	assign upd_carry = i_op.valid && i_op.update_carry;
	assign cr_wr     = i_op.valid && i_op.write_cr;
	assign swi       = i_op.valid && i_op.is_swi;
	assign rfe       = i_op.valid && i_op.is_rfe;
	assign load      = i_op.valid && i_op.mem_load;
	assign store     = i_op.valid && i_op.mem_store;
	assign is_branch = i_op.valid && (i_op.instr_class == CLASS_BRANCH);

	always_comb begin
		case (i_op.op1_src)
			OP1_RA:  op1 = i_op.ra;
			OP1_RB:  op1 = i_op.rb;
			default: op1 = i_op.pc_plus_4;
		endcase
	end

	assign op2 = i_op.op2_rb ? i_op.rb : i_op.imm32;

	always_comb begin
		case (i_op.branch_cond)
			BR_ALWAYS: cond_met = 1'b1;
			BR_NE:     cond_met = !psr.z;
			BR_EQ:     cond_met = psr.z;
			BR_NC:     cond_met = !psr.c;
			BR_C:      cond_met = psr.c;
			BR_GT:     cond_met = !psr.z && (psr.n == psr.o);
			BR_LT:     cond_met = psr.n != psr.o;
			default:   cond_met = 1'b0;
		endcase
	end

	exec_alu u_alu (
		.i_opc         (i_op.alu_opc),
		.i_op1         (op1),
		.i_op2         (op2),
		.i_carry_in    (psr.c),
		.i_cr_val      (cr_val),
		.i_vector_base (o_vector_base),
		.i_fault_addr  (fault_addr),
		.o_result      (alu_q),
		.o_c           (alu_c),
		.o_o           (alu_o),
		.o_n           (alu_n),
		.o_z           (alu_z)
	);

	control_regs u_cregs (
		.clk           (clk),
		.rst           (rst),
		.i_flags_wr    (upd_flags),
		.i_carry_wr    (upd_carry),
		.i_alu_c       (alu_c),
		.i_alu_o       (alu_o),
		.i_alu_n       (alu_n),
		.i_alu_z       (alu_z),
		.i_cr_sel      (i_op.cr_sel),
		.i_cr_wr_en    (cr_wr),
		.i_cr_wr_val   (i_op.ra),
		.i_is_swi      (swi),
		.i_is_rfe      (rfe),
		.i_exc         (i_exc),
		.i_pc_plus_4   (i_op.pc_plus_4),
		.i_mar         (o_res.mar),
		.i_dbg_sel     (i_dbg_sel),
		.i_dbg_wr_en   (i_dbg_wr_en),
		.i_dbg_wr_val  (i_dbg_wr_val),
		.o_psr         (psr),
		.o_cr_val      (cr_val),
		.o_dbg_val     (o_dbg_val),
		.o_vector_base (o_vector_base),
		.o_fault_addr  (fault_addr)
	);

	// ====================
	// Memory stage registers.
	always_ff @(posedge clk) begin
		if (rst) begin
			o_branch_taken  <= 1'b0;
			o_stall_clear   <= 1'b0;
			o_res.valid     <= 1'b0;
			o_res.wr_result <= 1'b0;
			o_res.mem_load  <= 1'b0;
			o_res.mem_store <= 1'b0;
			o_res.mem_wr_en <= 1'b0;
		end else begin
			o_branch_taken  <= (is_branch && cond_met) || swi || rfe;
			o_stall_clear   <= is_branch;
			o_res.valid     <= i_op.valid;
			o_res.wr_result <= i_op.valid && i_op.update_rd;
			o_res.mem_load  <= load;
			o_res.mem_store <= store;
			o_res.mem_wr_en <= store;
			o_res.alu_out   <= alu_q;
			o_res.rd_sel    <= i_op.rd_sel;
			o_res.pc_plus_4 <= i_op.pc_plus_4;

			if (i_op.is_call)
				o_res.wr_val <= i_op.pc_plus_4;
			else if (i_op.mem_store)
				o_res.wr_val <= op2;
			else
				o_res.wr_val <= alu_q;

			if (load || store) begin
				o_res.mem_width <= i_op.mem_width;
				o_res.mar       <= alu_q;
				o_res.mdr       <= i_op.rb;
			end
		end
	end

	assign o_irqs_enabled = psr.irq_en;

endmodule

// ==== source/exec_top.sv ====
module exec_top (
	input  logic                   clk,
	input  logic                   rst,
	input  exec_pkg::exec_op_t     i_op,
	input  cr_pkg::exc_event_t     i_exc,
	output exec_pkg::exec_result_t o_res,
	output logic                   o_branch_taken,
	output logic                   o_stall_clear,
	output logic                   o_irqs_enabled,
	output logic [25:0]            o_vector_base,
	input  cr_pkg::axil_aw_t       i_aw,
	input  logic                   i_aw_valid,
	output logic                   o_aw_ready,
	input  cr_pkg::axil_w_t        i_w,
	input  logic                   i_w_valid,
	output logic                   o_w_ready,
	output cr_pkg::axil_b_t        o_b,
	output logic                   o_b_valid,
	input  logic                   i_b_ready,
	input  cr_pkg::axil_ar_t       i_ar,
	input  logic                   i_ar_valid,
	output logic                   o_ar_ready,
	output cr_pkg::axil_r_t        o_r,
	output logic                   o_r_valid,
	input  logic                   i_r_ready
);
	logic [2:0]  dbg_sel;
	logic        dbg_wr_en;
	logic [31:0] dbg_wr_val;
	logic [31:0] dbg_val;

	exec_stage u_exec (
		.clk            (clk),
		.rst            (rst),
		.i_op           (i_op),
		.i_exc          (i_exc),
		.i_dbg_sel      (dbg_sel),
		.i_dbg_wr_en    (dbg_wr_en),
		.i_dbg_wr_val   (dbg_wr_val),
		.o_res          (o_res),
		.o_branch_taken (o_branch_taken),
		.o_stall_clear  (o_stall_clear),
		.o_irqs_enabled (o_irqs_enabled),
		.o_vector_base  (o_vector_base),
		.o_dbg_val      (dbg_val)
	);

	// Debugger access to the control registers.
	dbg_axil_slave u_dbg (
		.clk          (clk),
		.rst          (rst),
		.i_aw         (i_aw),
		.i_aw_valid   (i_aw_valid),
		.o_aw_ready   (o_aw_ready),
		.i_w          (i_w),
		.i_w_valid    (i_w_valid),
		.o_w_ready    (o_w_ready),
		.o_b          (o_b),
		.o_b_valid    (o_b_valid),
		.i_b_ready    (i_b_ready),
		.i_ar         (i_ar),
		.i_ar_valid   (i_ar_valid),
		.o_ar_ready   (o_ar_ready),
		.o_r          (o_r),
		.o_r_valid    (o_r_valid),
		.i_r_ready    (i_r_ready),
		.o_dbg_sel    (dbg_sel),
		.o_dbg_wr_en  (dbg_wr_en),
		.o_dbg_wr_val (dbg_wr_val),
		.i_dbg_val    (dbg_val)
	);

endmodule

// ==== test/exec_checker.sv ====
module exec_checker (
	input  logic                   clk,
	input  logic                   i_chk,
	input  logic [31:0]            i_exp_alu,
	input  logic [31:0]            i_exp_wr,
	input  logic [31:0]            i_exp_mdr,
	input  logic [7:0]             i_exp_flg,
	input  logic [31:0]            i_exp_rd,
	input  exec_pkg::exec_op_t     i_op,
	input  logic                   i_irq_chk,
	input  exec_pkg::exec_result_t i_res,
	input  logic                   i_branch_taken,
	input  logic                   i_stall_clear,
	input  logic                   i_irqs_enabled,
	input  logic [25:0]            i_vector_base,
	input  cr_pkg::axil_r_t        i_r,
	input  logic                   i_r_valid,
	input  logic                   i_r_ready,
	input  cr_pkg::axil_b_t        i_b,
	input  logic                   i_b_valid,
	input  logic                   i_b_ready,
	output int                     o_errors,
	output int                     o_tests
);
	timeunit 1ns;
	timeprecision 1ps;
	import exec_pkg::*;

	logic        pend = 1'b0;
	logic [31:0] e_alu, e_wr, e_mdr;
	logic [7:0]  e_flg;
	exec_op_t    e_op;
	int          bad = 0;
	int          errors = 0;
	int          tests = 0;

	assign o_errors = errors;
	assign o_tests  = tests;

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED %s expected %h got %h", name, exp, act);
			bad++;
		end
	endtask

	task automatic finish_test(input string what);
		tests++;
		if (bad != 0) begin
			errors++;
			$display("test %0d %s: mismatch", tests, what);
		end else begin
			$display("test %0d %s: ok", tests, what);
		end
	endtask

	// Pipeline results are compared one cycle after the op was registered.
	always @(posedge clk) begin
		if (pend) begin
			bad = 0;
			compare("o_res.alu_out", e_alu, i_res.alu_out);
			compare("o_res.wr_val", e_wr, i_res.wr_val);
			compare("o_branch_taken", {31'b0, e_flg[0]}, {31'b0, i_branch_taken});
			compare("o_stall_clear", {31'b0, e_flg[1]}, {31'b0, i_stall_clear});
			compare("o_res.mem_wr_en", {31'b0, e_flg[2]}, {31'b0, i_res.mem_wr_en});
			compare("o_res.wr_result", {31'b0, e_flg[3]}, {31'b0, i_res.wr_result});
			compare("o_res.valid", {31'b0, e_op.valid}, {31'b0, i_res.valid});
			compare("o_res.rd_sel", {28'b0, e_op.rd_sel}, {28'b0, i_res.rd_sel});
			compare("o_res.pc_plus_4", e_op.pc_plus_4, i_res.pc_plus_4);
			compare("o_res.mem_load", {31'b0, e_op.mem_load}, {31'b0, i_res.mem_load});
			compare("o_res.mem_store", {31'b0, e_op.mem_store}, {31'b0, i_res.mem_store});
			if (e_flg[4])
				compare("o_vector_base", e_alu, {i_vector_base, 6'b0});
			if (e_flg[5]) begin
				compare("o_res.mar", e_alu, i_res.mar);
				compare("o_res.mdr", e_mdr, i_res.mdr);
				compare("o_res.mem_width", {30'b0, e_op.mem_width}, {30'b0, i_res.mem_width});
			end
			finish_test("pipeline op");
		end
		if (i_r_valid && i_r_ready) begin
			bad = 0;
			compare("o_r.data", i_exp_rd, i_r.data);
			compare("o_r.resp", 32'b0, {30'b0, i_r.resp});
			// Bit 4 of the status word is the interrupt enable.
			if (i_irq_chk)
				compare("o_irqs_enabled", {31'b0, i_exp_rd[4]}, {31'b0, i_irqs_enabled});
			finish_test("debug read");
		end
		if (i_b_valid && i_b_ready) begin
			bad = 0;
			compare("o_b.resp", 32'b0, {30'b0, i_b.resp});
			finish_test("debug write");
		end
		pend  <= i_chk;
		e_alu <= i_exp_alu;
		e_wr  <= i_exp_wr;
		e_mdr <= i_exp_mdr;
		e_flg <= i_exp_flg;
		e_op  <= i_op;
	end

endmodule

// ==== test/exec_tb.sv ====
module exec_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import exec_pkg::*;
	import cr_pkg::*;

	localparam int TIMEOUT = 50;

	logic         clk = 1'b0;
	logic         rst;
	exec_op_t     op;
	exc_event_t   exc;
	exec_result_t res;
	logic         branch_taken, stall_clear, irqs_enabled;
	logic [25:0]  vector_base;
	axil_aw_t     aw;
	axil_w_t      w;
	axil_ar_t     ar;
	axil_b_t      b;
	axil_r_t      r;
	logic         aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
	logic         ar_valid, ar_ready, r_valid, r_ready;
	logic         chk;
	logic         irq_chk;
	logic         timed_out = 1'b0;
	logic [31:0]  exp_alu, exp_wr, exp_mdr, exp_rd;
	logic [7:0]   exp_flg;
	int           errors, tests;

	always #2 clk = ~clk;

	exec_top UUT (
		.clk(clk), .rst(rst), .i_op(op), .i_exc(exc), .o_res(res),
		.o_branch_taken(branch_taken), .o_stall_clear(stall_clear),
		.o_irqs_enabled(irqs_enabled), .o_vector_base(vector_base),
		.i_aw(aw), .i_aw_valid(aw_valid), .o_aw_ready(aw_ready),
		.i_w(w), .i_w_valid(w_valid), .o_w_ready(w_ready),
		.o_b(b), .o_b_valid(b_valid), .i_b_ready(b_ready),
		.i_ar(ar), .i_ar_valid(ar_valid), .o_ar_ready(ar_ready),
		.o_r(r), .o_r_valid(r_valid), .i_r_ready(r_ready)
	);

	exec_checker u_checker (
		.clk(clk), .i_chk(chk), .i_exp_alu(exp_alu), .i_exp_wr(exp_wr),
		.i_exp_mdr(exp_mdr), .i_exp_flg(exp_flg), .i_exp_rd(exp_rd),
		.i_op(op), .i_irq_chk(irq_chk),
		.i_res(res), .i_branch_taken(branch_taken), .i_stall_clear(stall_clear),
		.i_irqs_enabled(irqs_enabled),
		.i_vector_base(vector_base), .i_r(r), .i_r_valid(r_valid), .i_r_ready(r_ready),
		.i_b(b), .i_b_valid(b_valid), .i_b_ready(b_ready),
		.o_errors(errors), .o_tests(tests)
	);

	// Control word bits: flags, carry, write_cr, swi, rfe, load, store, call, branch, cond.
	function automatic exec_op_t build_op(input logic [11:0] ctl, input logic [31:0] ra,
			input logic [31:0] rb, input logic [31:0] pc, input logic [4:0] opc,
			input logic [2:0] crsel);
		exec_op_t o;
		o = '0;
		o.ra = ra;
		o.rb = rb;
		o.pc_plus_4 = pc;
		o.alu_opc = opc;
		o.op1_src = OP1_RA;
		o.op2_rb = 1'b1;
		o.update_flags = ctl[0];
		o.update_carry = ctl[1];
		o.write_cr = ctl[2];
		o.is_swi = ctl[3];
		o.is_rfe = ctl[4];
		o.mem_load = ctl[5];
		o.mem_store = ctl[6];
		o.is_call = ctl[7];
		o.instr_class = ctl[8] ? CLASS_BRANCH : CLASS_ARITH;
		o.branch_cond = ctl[11:9];
		o.cr_sel = crsel;
		o.mem_width = 2'd2;
		o.rd_sel = 4'd1;
		o.update_rd = !ctl[6] && (!ctl[8] || ctl[7]);
		o.valid = 1'b1;
		return o;
	endfunction

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		timed_out = 1'b1;
	endtask

	task automatic go_idle();
		@(posedge clk);
		op  <= '0;
		chk <= 1'b0;
	endtask

	task automatic debug_write(input logic [31:0] addr, input logic [31:0] data,
			input logic with_pipe, input logic [31:0] pipe_val, input logic [2:0] crsel);
		int  n;
		logic aw_done, w_done;
		go_idle();
		aw <= '{addr: addr};
		w  <= '{data: data, strb: 4'hf};
		aw_valid <= 1'b1;
		w_valid  <= 1'b1;
		n = 0;
		aw_done = 1'b0;
		w_done = 1'b0;
		while (!(aw_done && w_done)) begin
			@(posedge clk);
			if (aw_valid && aw_ready) begin
				aw_done = 1'b1;
				aw_valid <= 1'b0;
			end
			if (w_valid && w_ready) begin
				w_done = 1'b1;
				w_valid <= 1'b0;
			end
			n++;
			if (n > TIMEOUT) begin
				report_timeout("AW/W ready");
				return;
			end
		end
		// The pipeline write lands on the same edge as the debug strobe.
		if (with_pipe) begin
			op <= build_op(12'h004, pipe_val, 32'b0, 32'b0, ALU_ADD, crsel);
			go_idle();
		end
		repeat ($urandom_range(3, 0)) @(posedge clk);
		b_ready <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT) begin
				report_timeout("BVALID");
				return;
			end
		end while (!(b_valid && b_ready));
		b_ready <= 1'b0;
	endtask

	task automatic debug_read(input logic [31:0] addr, input logic [31:0] expect_val);
		int n;
		go_idle();
		exp_rd <= expect_val;
		irq_chk <= (addr[31:5] == 27'b0) && (addr[4:2] == CR_PSR);
		ar <= '{addr: addr};
		ar_valid <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT) begin
				report_timeout("ARREADY");
				return;
			end
		end while (!(ar_valid && ar_ready));
		ar_valid <= 1'b0;
		repeat ($urandom_range(3, 0)) @(posedge clk);
		r_ready <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT) begin
				report_timeout("RVALID");
				return;
			end
		end while (!(r_valid && r_ready));
		r_ready <= 1'b0;
	endtask

	initial begin
		int          fd, cnt;
		string       line;
		logic [3:0]  kind;
		logic [11:0] ctl;
		logic [31:0] ra, rb, pc, e_alu, e_wr;
		logic [4:0]  opc;
		logic [2:0]  crsel;
		logic [7:0]  e_flg;
		rst = 1'b1;
		op = '0;
		exc = '0;
		aw = '0;
		w = '0;
		ar = '0;
		aw_valid = 1'b0;
		w_valid = 1'b0;
		ar_valid = 1'b0;
		b_ready = 1'b0;
		r_ready = 1'b0;
		chk = 1'b0;
		irq_chk = 1'b0;
		exp_alu = '0;
		exp_wr = '0;
		exp_mdr = '0;
		exp_flg = '0;
		exp_rd = '0;
		void'($urandom(65441));
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		fd = $fopen("test/exec_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file");
			$display("TB FAILED");
			$finish;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = "";
				cnt = $fgets(line, fd);
				if (line.len() < 2 || line[0] == "#")
					continue;
				cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
					kind, ctl, ra, rb, pc, opc, crsel, e_alu, e_wr, e_flg);
				if (cnt != 10)
					continue;
				case (kind)
					4'd0: begin
						@(posedge clk);
						op      <= build_op(ctl, ra, rb, pc, opc, crsel);
						chk     <= 1'b1;
						exp_alu <= e_alu;
						exp_wr  <= e_wr;
						exp_mdr <= rb;
						exp_flg <= e_flg;
					end
					4'd1: debug_write(ra, rb, 1'b0, 32'b0, 3'd0);
					4'd2: debug_read(ra, e_alu);
					default: debug_write(ra, rb, 1'b1, pc, crsel);
				endcase
			end
			$fclose(fd);
			go_idle();
			repeat (3) @(posedge clk);
			$display("Tests run: %0d, errors: %0d", tests, errors);
			if (errors == 0 && tests > 0 && !timed_out)
				$display("TB PASSED");
			else
				$display("TB FAILED");
			$finish;
		end
	end

endmodule

// ==== test/exec_patterns.txt ====
# kind ctl ra rb pc opc cr exp_alu exp_wr exp_flg (kind 0 op, 1 dbg write, 2 dbg read, 3 race)
# ctl and exp_flg bits are decoded in exec_tb and exec_checker; debug rows use ra=addr rb=data
0 003 ffffffff 00000002 00000000 00 0 00000001 00000001 08
0 002 00000010 00000020 00000000 01 0 00000031 00000031 08
0 000 00000005 00000007 00000000 02 0 fffffffe fffffffe 08
0 000 80000001 00000004 00000000 04 0 00000010 00000010 08
0 000 80000000 0000001f 00000000 05 0 00000001 00000001 08
0 000 f0f0ff00 0ff0f0f0 00000000 06 0 00f0f000 00f0f000 08
0 000 f0f0ff00 0ff0f0f0 00000000 07 0 ff000ff0 ff000ff0 08
0 000 ffffffff 00000004 00000000 08 0 ffffffef ffffffef 08
0 000 00000000 0000001f 00000000 09 0 80000000 80000000 08
0 000 12340000 00005678 00000000 0a 0 12345678 12345678 08
0 000 abcd0000 00001234 00000000 0d 0 abcd1234 abcd1234 08
0 000 80000000 00000004 00000000 0e 0 f8000000 f8000000 08
0 003 00000003 00000005 00000000 0c 0 fffffffe fffffffe 08
0 300 00000000 00000000 00000000 00 0 00000000 00000000 03
0 500 00000000 00000000 00000000 00 0 00000000 00000000 02
0 700 00000000 00000000 00000000 00 0 00000000 00000000 02
0 900 00000000 00000000 00000000 00 0 00000000 00000000 03
0 b00 00000000 00000000 00000000 00 0 00000000 00000000 02
0 d00 00000000 00000000 00000000 00 0 00000000 00000000 03
0 f00 00000000 00000000 00000000 00 0 00000000 00000000 03
0 020 00001000 00000004 00000000 00 0 00001004 00001004 28
0 040 00002000 cafef00d 00000000 0f 0 00002000 cafef00d 24
0 f80 00000000 00000000 00000400 00 0 00000000 00000400 0b
0 004 12345678 00000000 00000000 00 0 12345678 12345678 08
0 000 00000000 00000000 00000000 10 0 12345640 12345640 18
0 004 0badf00d 00000000 00000000 00 3 0badf00d 0badf00d 08
0 000 00000000 00000000 00000000 10 3 0badf00d 0badf00d 08
0 004 00c0ffee 00000000 00000000 00 4 00c0ffee 00c0ffee 08
0 000 00000000 00000000 00000000 10 4 00c0ffee 00c0ffee 08
0 008 00000000 00000000 00000000 11 0 12345648 12345648 09
0 000 00000000 00000000 00000000 10 2 0000000a 0000000a 08
0 003 00000005 00000005 00000000 0c 0 00000000 00000000 08
0 000 00000000 00000000 00000000 10 1 00000001 00000001 08
0 010 00000000 00000000 00000000 12 0 0badf00d 0badf00d 09
0 000 00000000 00000000 00000000 10 1 0000000a 0000000a 08
1 000 00000000 ffffffff 00000000 00 0 00000000 00000000 00
2 000 00000000 00000000 00000000 00 0 ffffffc0 00000000 00
1 000 00000004 0000001f 00000000 00 0 00000000 00000000 00
2 000 00000004 00000000 00000000 00 0 0000001f 00000000 00
1 000 00000008 ffffffe5 00000000 00 0 00000000 00000000 00
2 000 00000008 00000000 00000000 00 0 00000005 00000000 00
1 000 0000000c 13572468 00000000 00 0 00000000 00000000 00
2 000 0000000c 00000000 00000000 00 0 13572468 00000000 00
1 000 00000010 89abcdef 00000000 00 0 00000000 00000000 00
2 000 00000010 00000000 00000000 00 0 89abcdef 00000000 00
2 000 00000014 00000000 00000000 00 0 00000000 00000000 00
2 000 00000018 00000000 00000000 00 0 00000000 00000000 00
2 000 0000001c 00000000 00000000 00 0 00000000 00000000 00
2 000 00000040 00000000 00000000 00 0 00000000 00000000 00
3 000 0000000c 11111111 22222222 00 3 00000000 00000000 00
2 000 0000000c 00000000 00000000 00 0 11111111 00000000 00

// ==== flist.f ====
source/exec_pkg.sv
source/cr_pkg.sv
source/exec_alu.sv
source/control_regs.sv
source/dbg_axil_slave.sv
source/exec_stage.sv
source/exec_top.sv
test/exec_checker.sv
test/exec_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module exec_tb -Mdir obj_dir -f flist.f

run: compile
	./obj_dir/Vexec_tb | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
